//--- compile.f
+incdir+design
design/ddc_pkg.sv
design/ddc_settings.sv
design/ddc_nco.sv
design/ddc_mixer.sv
design/ddc_cic_decim.sv
design/ddc_iq_scale.sv
design/ddc_top.sv
tb/ddc_clk_gen.sv
tb/ddc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the DDC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ddc_tb -f compile.f -o ddc_sim

out=$(./obj_dir/ddc_sim)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

//--- tb/ddc_tb.sv
/* DDC testbench
   Drives settings and samples, predicts every output and checks it by assertions */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_tb;

  logic        ce_clk;
  logic        rst_n;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [7:0]  rb_addr;
  logic        in_stb;
  logic [31:0] in_data;
  logic [63:0] rb_data;
  logic        out_stb;
  logic [31:0] out_data;

  string       test_name;
  int          value_errors;
  int          strobe_errors;
  int          timeout_errors;
  int          out_count;
  int          const_base;
  logic        const_armed;
  logic [31:0] const_exp;

  // Model copy of the settings and datapath state
  logic [31:0] m_freq;
  logic [31:0] m_phase;
  logic [15:0] m_scale;
  int          m_decim;
  logic [1:0]  m_mux;
  int          m_count;
  int          m_hist_i[$];
  int          m_hist_q[$];
  logic [4:0]  exp_stb_pipe;
  logic [31:0] exp_data_pipe [5];

  ddc_clk_gen clk_gen (.o_clk(ce_clk), .o_rst_n(rst_n));

  ddc_top uut (
    .ce_clk(ce_clk), .i_rst_n(rst_n),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_rb_addr(rb_addr), .i_in_stb(in_stb), .i_in_data(in_data),
    .o_rb_data(rb_data), .o_out_stb(out_stb), .o_out_data(out_data));

  function automatic logic [15:0] sat16(input longint v);
    if (v > 32767)
      return 16'h7fff;
    if (v < -32768)
      return 16'h8000;
    return v[15:0];
  endfunction

  // Q2.14 gain on the 32-bit CIC value with floor shift
  function automatic logic [15:0] scale_word(input longint v, input logic [15:0] s);
    longint p;
    p = longint'(int'(v)) * longint'(s);
    return sat16(p >>> 14);
  endfunction

  // Downconversion by a quarter-turn angle with I in the upper half
  function automatic logic [31:0] rotate(input int i, input int q, input logic [1:0] quad);
    int c;
    int s;
    c = (quad == 2'd0) ? 16384 : (quad == 2'd2) ? -16384 : 0;
    s = (quad == 2'd1) ? 16384 : (quad == 2'd3) ? -16384 : 0;
    return {sat16(longint'(((i * c) >>> 14) + ((q * s) >>> 14))),
            sat16(longint'(((q * c) >>> 14) - ((i * s) >>> 14)))};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model predicting strobe and data 5 cycles out
  //////////////////////////////////////////////////////////////////////
  always @(posedge ce_clk) begin : model
    int          mi;
    int          mq;
    int          w;
    longint      acc_i;
    longint      acc_q;
    logic [31:0] rot;
    logic        stb_n;
    logic [31:0] data_n;
    stb_n = 1'b0;
    data_n = '0;
    if (!rst_n) begin
      m_freq = '0;
      m_phase = '0;
      m_scale = 16'd16384;
      m_decim = 1;
      m_mux = '0;
      m_count = 0;
      m_hist_i.delete();
      m_hist_q.delete();
    end else if (set_stb) begin
      case (set_addr)
        `SR_FREQ_ADDR:     m_freq = set_data;
        `SR_SCALE_IQ_ADDR: m_scale = set_data[15:0];
        `SR_DECIM_ADDR:    m_decim = (set_data[7:0] == 8'd0) ? 1 : int'(set_data[7:0]);
        `SR_MUX_ADDR:      m_mux = set_data[1:0];
        default: ;
      endcase
      // New frequency or rate restarts phase and CIC history
      if (set_addr == `SR_FREQ_ADDR || set_addr == `SR_DECIM_ADDR) begin
        m_phase = '0;
        m_count = 0;
        m_hist_i.delete();
        m_hist_q.delete();
      end
    end else if (in_stb) begin
      mi = int'($signed(in_data[31:16]));
      mq = int'($signed(in_data[15:0]));
      if (m_mux[0]) begin
        w = mi;
        mi = mq;
        mq = w;
      end
      if (m_mux[1])
        mq = 0;
      rot = rotate(mi, mq, m_phase[31:30]);
      m_phase = m_phase + m_freq;
      m_hist_i.push_front(int'($signed(rot[31:16])));
      m_hist_q.push_front(int'($signed(rot[15:0])));
      if (m_hist_i.size() > 2 * m_decim - 1) begin
        void'(m_hist_i.pop_back());
        void'(m_hist_q.pop_back());
      end
      m_count++;
      if (m_count == m_decim) begin
        acc_i = 0;
        acc_q = 0;
        // Two cascaded boxcars give a triangular window
        for (int k = 0; k < m_hist_i.size(); k++) begin
          w = (k < m_decim) ? k + 1 : 2 * m_decim - 1 - k;
          acc_i += longint'(m_hist_i[k]) * w;
          acc_q += longint'(m_hist_q[k]) * w;
        end
        stb_n = 1'b1;
        data_n = {scale_word(acc_i, m_scale), scale_word(acc_q, m_scale)};
        m_count = 0;
      end
    end
    if (!rst_n)
      exp_stb_pipe <= '0;
    else
      exp_stb_pipe <= {exp_stb_pipe[3:0], stb_n};
    exp_data_pipe[0] <= data_n;
    for (int k = 1; k < 5; k++)
      exp_data_pipe[k] <= exp_data_pipe[k-1];
  end

  always @(posedge ce_clk) begin
    if (!rst_n)
      out_count <= 0;
    else if (out_stb)
      out_count <= out_count + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////////////////////////
  a_out_stb: assert property (@(posedge ce_clk) disable iff (!rst_n)
    out_stb == exp_stb_pipe[4])
    else begin
      strobe_errors++;
      $display("FAIL %s: out_stb expected %0b actual %0b", test_name,
               $sampled(exp_stb_pipe[4]), $sampled(out_stb));
    end

  a_out_data: assert property (@(posedge ce_clk) disable iff (!rst_n)
    (out_stb && exp_stb_pipe[4]) |-> (out_data == exp_data_pipe[4]))
    else begin
      value_errors++;
      $display("FAIL %s: out_data expected %h actual %h", test_name,
               $sampled(exp_data_pipe[4]), $sampled(out_data));
    end

  // Settled CIC level for a constant input
  a_const_level: assert property (@(posedge ce_clk) disable iff (!rst_n)
    (out_stb && const_armed && (out_count - const_base >= 2)) |-> (out_data == const_exp))
    else begin
      value_errors++;
      $display("FAIL %s: settled level expected %h actual %h", test_name,
               $sampled(const_exp), $sampled(out_data));
    end

  task automatic check_readback(input logic [7:0] addr, input logic [63:0] exp);
    @(negedge ce_clk);
    rb_addr = addr;
    @(posedge ce_clk);
    a_rb: assert (rb_data == exp)
      else begin
        value_errors++;
        $display("FAIL %s: addr %0d expected %h actual %h", test_name, addr, exp, rb_data);
      end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    in_stb = 1'b0;
    set_stb = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge ce_clk);
    set_stb = 1'b0;
  endtask

  task automatic send_sample(input logic [31:0] d);
    @(negedge ce_clk);
    in_stb = 1'b1;
    in_data = d;
  endtask

  task automatic send_random(input int n);
    for (int k = 0; k < n; k++) begin
      // Occasional idle cycle between samples
      if (($urandom % 4) == 0) begin
        @(negedge ce_clk);
        in_stb = 1'b0;
      end
      send_sample($urandom);
    end
  endtask

  task automatic wait_outputs(input int target);
    int n;
    n = 0;
    @(negedge ce_clk);
    in_stb = 1'b0;
    while (out_count < target && n < 200) begin
      @(negedge ce_clk);
      n++;
    end
    if (out_count < target) begin
      timeout_errors++;
      $display("Timeout in %s: only %0d of %0d outputs arrived", test_name, out_count, target);
    end
  endtask

  initial begin : stimulus
    int n;
    int base;
    int dn;
    void'($urandom(32'h35ef84f4));
    set_stb = 1'b0;
    set_addr = '0;
    set_data = '0;
    rb_addr = '0;
    in_stb = 1'b0;
    in_data = '0;
    value_errors = 0;
    strobe_errors = 0;
    timeout_errors = 0;
    const_base = 0;
    const_armed = 1'b0;
    const_exp = '0;
    test_name = "reset";
    n = 0;
    while (rst_n !== 1'b1 && n < 50) begin
      @(negedge ce_clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      timeout_errors++;
      $display("Timeout: reset was never released");
    end

    test_name = "readback";
    check_readback(`RB_COMPAT_NUM, 64'h0000_0001_0000_0000);
    check_readback(`RB_CIC_ORDER, 64'd2);
    check_readback(`RB_CIC_MAX_DECIM, 64'd255);
    check_readback(8'd7, 64'h0BAD_C0DE_0BAD_C0DE);

    test_name = "passthrough";
    base = out_count;
    send_random(40);
    wait_outputs(base + 40);

    for (int m = 1; m < 4; m++) begin
      test_name = $sformatf("mux_%0d", m);
      write_setting(`SR_MUX_ADDR, 32'(m));
      base = out_count;
      send_random(16);
      wait_outputs(base + 16);
    end
    write_setting(`SR_MUX_ADDR, 32'd0);

    // Full-scale negative corner saturates once negated
    test_name = "quarter_turn";
    write_setting(`SR_FREQ_ADDR, 32'h4000_0000);
    base = out_count;
    repeat (4) send_sample(32'h8000_8000);
    send_random(12);
    wait_outputs(base + 16);
    write_setting(`SR_FREQ_ADDR, 32'd0);

    for (int s = 0; s < 2; s++) begin
      dn = (s == 0) ? 3 : 8;
      test_name = $sformatf("decim_%0d", dn);
      write_setting(`SR_SCALE_IQ_ADDR, 32'(16384 / (dn * dn)));
      write_setting(`SR_DECIM_ADDR, 32'(dn));
      base = out_count;
      const_base = base;
      const_exp = {scale_word(longint'(11000 * dn * dn), 16'(16384 / (dn * dn))),
                   scale_word(longint'(-7000 * dn * dn), 16'(16384 / (dn * dn)))};
      const_armed = 1'b1;
      repeat (6 * dn) send_sample({16'sd11000, -16'sd7000});
      wait_outputs(base + 6);
      const_armed = 1'b0;
    end

    test_name = "gain_saturation";
    write_setting(`SR_DECIM_ADDR, 32'd1);
    write_setting(`SR_SCALE_IQ_ADDR, 32'h0000_ffff);
    base = out_count;
    repeat (3) send_sample({16'sd20000, -16'sd20000});
    send_random(8);
    wait_outputs(base + 11);

    repeat (10) @(negedge ce_clk);
    $display("Error counts: value %0d, strobe %0d, timeout %0d",
             value_errors, strobe_errors, timeout_errors);
    if (value_errors + strobe_errors + timeout_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tb/ddc_clk_gen.sv
/* Clock and reset source for the DDC testbench
   4 ns ce_clk, reset held low for the first 4 cycles */
`timescale 1ns/10ps

module ddc_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  // Released on a falling edge, clear of the sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

//--- design/ddc_top.sv
/* Digital down-converter top level
   Settings block feeding NCO, mixer, CIC decimator and gain stage */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_top (
  input  logic        ce_clk,
  input  logic        i_rst_n,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [7:0]  i_rb_addr,
  input  logic        i_in_stb,
  input  logic [31:0] i_in_data,
  output logic [63:0] o_rb_data,
  output logic        o_out_stb,
  output logic [31:0] o_out_data
);

  logic [`PHASE_W-1:0]         freq;
  logic [15:0]                 scale;
  logic [7:0]                  decim;
  logic [1:0]                  mux;
  logic                        clear;
  logic                        nco_stb;
  logic signed [`SAMPLE_W-1:0] nco_cos, nco_sin;
  logic                        mix_stb;
  ddc_pkg::ddc_sample_t        mix_data;
  logic                        cic_stb;
  logic signed [31:0]          cic_i, cic_q;

  //////////////////////////////////////////////////////////////////////
  // Settings and readback
  //////////////////////////////////////////////////////////////////////
  ddc_settings settings (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_addr(i_rb_addr), .o_rb_data(o_rb_data),
    .o_freq(freq), .o_scale(scale), .o_decim(decim), .o_mux(mux),
    .o_clear(clear));

  //////////////////////////////////////////////////////////////////////
  // Sample path, 5 cycles from input strobe to output strobe
  //////////////////////////////////////////////////////////////////////
  ddc_nco nco (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_clear(clear),
    .i_stb(i_in_stb), .i_freq(freq),
    .o_stb(nco_stb), .o_cos(nco_cos), .o_sin(nco_sin));

  // Raw input goes straight in, mixer lines it up with the NCO
  ddc_mixer mixer (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_clear(clear),
    .i_stb(nco_stb), .i_data(i_in_data), .i_mux(mux),
    .i_cos(nco_cos), .i_sin(nco_sin),
    .o_stb(mix_stb), .o_data(mix_data));

  ddc_cic_decim cic (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_clear(clear),
    .i_stb(mix_stb), .i_data(mix_data), .i_decim(decim),
    .o_stb(cic_stb), .o_i(cic_i), .o_q(cic_q));

  ddc_iq_scale iq_scale (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_clear(clear),
    .i_stb(cic_stb), .i_i(cic_i), .i_q(cic_q), .i_scale(scale),
    .o_stb(o_out_stb), .o_data(o_out_data));

endmodule

//--- design/ddc_iq_scale.sv
/* Output gain stage
   Multiplies by the Q2.14 gain, shifts and saturates to 16 bits */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_iq_scale (
  input  logic                 ce_clk,
  input  logic                 i_rst_n,
  input  logic                 i_clear,
  input  logic                 i_stb,
  input  logic signed [31:0]   i_i,
  input  logic signed [31:0]   i_q,
  input  logic [15:0]          i_scale,
  output logic                 o_stb,
  output ddc_pkg::ddc_sample_t o_data
);

  logic signed [16:0] gain;
  logic signed [48:0] prod_i, prod_q;

  function automatic logic signed [`SAMPLE_W-1:0] sat16(input logic signed [34:0] v);
    if (v > 35'sd32767)
      return 16'sh7fff;
    else if (v < -35'sd32768)
      return 16'sh8000;
    else
      return v[15:0];
  endfunction

  // Gain is unsigned, keep it positive in signed math
  assign gain   = {1'b0, i_scale};
  assign prod_i = i_i * gain;
  assign prod_q = i_q * gain;

  always_ff @(posedge ce_clk) begin
    if (i_stb) begin
      o_data.iq.i <= sat16(prod_i[48:14]);
      o_data.iq.q <= sat16(prod_q[48:14]);
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear)
      o_stb <= 1'b0;
    else
      o_stb <= i_stb;
  end

endmodule

//--- design/ddc_cic_decim.sv
/* Second-order CIC decimator
   Integrates every input and combs on every decim-th one */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_cic_decim (
  input  logic                 ce_clk,
  input  logic                 i_rst_n,
  input  logic                 i_clear,
  input  logic                 i_stb,
  input  ddc_pkg::ddc_sample_t i_data,
  input  logic [7:0]           i_decim,
  output logic                 o_stb,
  output logic signed [31:0]   o_i,
  output logic signed [31:0]   o_q
);

  localparam int ACC_W = 32;
  localparam int EXT_W = ACC_W - `SAMPLE_W;

  // Index 0 carries I, index 1 carries Q
  logic signed [ACC_W-1:0] x         [2];
  logic signed [ACC_W-1:0] integ1    [2];
  logic signed [ACC_W-1:0] integ2    [2];
  logic signed [ACC_W-1:0] integ1_nx [2];
  logic signed [ACC_W-1:0] integ2_nx [2];
  logic signed [ACC_W-1:0] dly1      [2];
  logic signed [ACC_W-1:0] dly2      [2];
  logic signed [ACC_W-1:0] comb1     [2];
  logic signed [ACC_W-1:0] comb2     [2];
  logic [7:0]              rate_cnt;
  logic                    last;

  assign x[0] = {{EXT_W{i_data.iq.i[`SAMPLE_W-1]}}, i_data.iq.i};
  assign x[1] = {{EXT_W{i_data.iq.q[`SAMPLE_W-1]}}, i_data.iq.q};

  // Full width wraps harmlessly, gain is decim squared
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      integ1_nx[c] = integ1[c] + x[c];
      integ2_nx[c] = integ2[c] + integ1_nx[c];
      comb1[c]     = integ2_nx[c] - dly1[c];
      comb2[c]     = comb1[c] - dly2[c];
    end
  end

  assign last = (rate_cnt >= i_decim - 8'd1);

  //////////////////////////////////////////////////////////////////////
  // Integrators, comb delays and rate counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      rate_cnt <= '0;
      o_stb    <= 1'b0;
      for (int c = 0; c < 2; c++) begin
        integ1[c] <= '0;
        integ2[c] <= '0;
        dly1[c]   <= '0;
        dly2[c]   <= '0;
      end
    end else begin
      o_stb <= i_stb && last;
      if (i_stb) begin
        rate_cnt <= last ? 8'd0 : rate_cnt + 8'd1;
        for (int c = 0; c < 2; c++) begin
          integ1[c] <= integ1_nx[c];
          integ2[c] <= integ2_nx[c];
          if (last) begin
            dly1[c] <= integ2_nx[c];
            dly2[c] <= comb1[c];
          end
        end
      end
    end
  end

  // Decimated output
  always_ff @(posedge ce_clk) begin
    if (i_stb && last) begin
      o_i <= comb2[0];
      o_q <= comb2[1];
    end
  end

  a_out_follows_in: assert property (
    @(posedge ce_clk) disable iff (!i_rst_n) o_stb |-> $past(i_stb));

endmodule

//--- design/ddc_mixer.sv
/* Input I/Q mux and complex rotation
   Mixes the sample down by the NCO angle with floor shift and saturation */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_mixer (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  input  logic                        i_clear,
  input  logic                        i_stb,
  input  ddc_pkg::ddc_sample_t        i_data,
  input  logic [1:0]                  i_mux,
  input  logic signed [`SAMPLE_W-1:0] i_cos,
  input  logic signed [`SAMPLE_W-1:0] i_sin,
  output logic                        o_stb,
  output ddc_pkg::ddc_sample_t        o_data
);

  ddc_pkg::ddc_sample_t muxed;
  ddc_pkg::ddc_sample_t held;
  logic signed [31:0]   p_ic, p_qs, p_qc, p_is;
  logic signed [17:0]   t_ic, t_qs, t_qc, t_is;
  logic signed [18:0]   sum_i, sum_q;
  logic                 stb_p;

  function automatic logic signed [`SAMPLE_W-1:0] sat16(input logic signed [18:0] v);
    if (v > 19'sd32767)
      return 16'sh7fff;
    else if (v < -19'sd32768)
      return 16'sh8000;
    else
      return v[15:0];
  endfunction

  // Swap first, then optionally drop Q
  always_comb begin
    muxed = i_data;
    if (i_mux[0]) begin
      muxed.iq.i = i_data.iq.q;
      muxed.iq.q = i_data.iq.i;
    end
    if (i_mux[1])
      muxed.iq.q = '0;
  end

  // NCO output lags the input by one cycle
  always_ff @(posedge ce_clk) begin
    held <= muxed;
  end

  assign p_ic = held.iq.i * i_cos;
  assign p_qs = held.iq.q * i_sin;
  assign p_qc = held.iq.q * i_cos;
  assign p_is = held.iq.i * i_sin;

  // Upper bits are the product shifted right by 14, floor
  always_ff @(posedge ce_clk) begin
    if (i_stb) begin
      t_ic <= p_ic[31:14];
      t_qs <= p_qs[31:14];
      t_qc <= p_qc[31:14];
      t_is <= p_is[31:14];
    end
  end

  assign sum_i = t_ic + t_qs;
  assign sum_q = t_qc - t_is;

  always_ff @(posedge ce_clk) begin
    if (stb_p) begin
      o_data.iq.i <= sat16(sum_i);
      o_data.iq.q <= sat16(sum_q);
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      stb_p <= 1'b0;
      o_stb <= 1'b0;
    end else begin
      stb_p <= i_stb;
      o_stb <= stb_p;
    end
  end

  a_stb_latency: assert property (
    @(posedge ce_clk) disable iff (!i_rst_n || i_clear) i_stb |-> ##2 o_stb);

endmodule

//--- design/ddc_nco.sv
/* Numerically controlled oscillator
   Phase accumulator with a folded quarter-wave sine/cosine table */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_nco (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  input  logic                        i_clear,
  input  logic                        i_stb,
  input  logic [`PHASE_W-1:0]         i_freq,
  output logic                        o_stb,
  output logic signed [`SAMPLE_W-1:0] o_cos,
  output logic signed [`SAMPLE_W-1:0] o_sin
);

  localparam logic signed [`SAMPLE_W-1:0] AMP = `NCO_AMP;

  logic [`PHASE_W-1:0]         phase;
  logic [1:0]                  quad;
  logic [3:0]                  idx;
  logic signed [`SAMPLE_W-1:0] t_near;
  logic signed [`SAMPLE_W-1:0] t_far;

  // sin(2*pi*k/64) scaled to the peak, k = 0..16
  function automatic logic signed [`SAMPLE_W-1:0] quarter_sin(input logic [4:0] k);
    case (k)
      5'd0:    return 16'sd0;
      5'd1:    return 16'sd1606;
      5'd2:    return 16'sd3196;
      5'd3:    return 16'sd4756;
      5'd4:    return 16'sd6270;
      5'd5:    return 16'sd7723;
      5'd6:    return 16'sd9102;
      5'd7:    return 16'sd10394;
      5'd8:    return 16'sd11585;
      5'd9:    return 16'sd12665;
      5'd10:   return 16'sd13623;
      5'd11:   return 16'sd14449;
      5'd12:   return 16'sd15137;
      5'd13:   return 16'sd15679;
      5'd14:   return 16'sd16069;
      5'd15:   return 16'sd16305;
      default: return AMP;
    endcase
  endfunction

  // Top two bits pick the quadrant, next four the table entry
  assign quad   = phase[`PHASE_W-1 -: 2];
  assign idx    = phase[`PHASE_W-3 -: 4];
  assign t_near = quarter_sin({1'b0, idx});
  assign t_far  = quarter_sin(5'd16 - {1'b0, idx});

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || i_clear) begin
      phase <= '0;
      o_stb <= 1'b0;
    end else begin
      o_stb <= i_stb;
      if (i_stb)
        phase <= phase + i_freq;
    end
  end

  // Uses the phase before this strobe's increment
  always_ff @(posedge ce_clk) begin
    if (i_stb) begin
      case (quad)
        2'd0: begin
          o_cos <= t_far;
          o_sin <= t_near;
        end
        2'd1: begin
          o_cos <= -t_near;
          o_sin <= t_far;
        end
        2'd2: begin
          o_cos <= -t_far;
          o_sin <= -t_near;
        end
        default: begin
          o_cos <= t_near;
          o_sin <= -t_far;
        end
      endcase
    end
  end

endmodule

//--- design/ddc_settings.sv
/* DDC settings registers
   Decodes settings bus writes, makes the clear pulse and serves readback */
`timescale 1ns/10ps
`include "ddc_macros.svh"

module ddc_settings (
  input  logic        ce_clk,
  input  logic        i_rst_n,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [7:0]  i_rb_addr,
  output logic [63:0] o_rb_data,
  output logic [31:0] o_freq,
  output logic [15:0] o_scale,
  output logic [7:0]  o_decim,
  output logic [1:0]  o_mux,
  output logic        o_clear
);

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_freq  <= '0;
      // Unity gain, 1.0 in Q2.14
      o_scale <= 16'd16384;
      o_decim <= 8'd1;
      o_mux   <= '0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        `SR_FREQ_ADDR:     o_freq  <= i_set_data;
        `SR_SCALE_IQ_ADDR: o_scale <= i_set_data[15:0];
        // A rate of zero means no decimation
        `SR_DECIM_ADDR:    o_decim <= (i_set_data[7:0] == 8'd0) ? 8'd1 : i_set_data[7:0];
        `SR_MUX_ADDR:      o_mux   <= i_set_data[1:0];
        default: ;
      endcase
    end
  end

  // New frequency or rate restarts NCO phase and CIC state
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_clear <= 1'b0;
    end else begin
      o_clear <= i_set_stb &&
                 ((i_set_addr == `SR_FREQ_ADDR) || (i_set_addr == `SR_DECIM_ADDR));
    end
  end

  always_comb begin
    case (i_rb_addr)
      `RB_COMPAT_NUM:    o_rb_data = `COMPAT_NUM;
      `RB_CIC_ORDER:     o_rb_data = 64'(`CIC_ORDER);
      `RB_CIC_MAX_DECIM: o_rb_data = 64'(`CIC_MAX_DECIM);
      default:           o_rb_data = `RB_DEFAULT;
    endcase
  end

  // CIC rate counter relies on a nonzero rate at all times
  a_decim_nonzero: assert property (
    @(posedge ce_clk) disable iff (!i_rst_n) o_decim != 8'd0);

endmodule

//--- design/ddc_pkg.sv
/* Sample types shared by the down-converter datapath
   One complex sample is a 32-bit word or an I/Q pair */
`include "ddc_macros.svh"

package ddc_pkg;

  // Complex sample, I in the upper half
  typedef struct packed {
    logic signed [`SAMPLE_W-1:0] i;
    logic signed [`SAMPLE_W-1:0] q;
  } ddc_iq_t;

  // Same 32 bits seen as a raw bus word or as I/Q
  typedef union packed {
    logic [2*`SAMPLE_W-1:0] word;
    ddc_iq_t                iq;
  } ddc_sample_t;

endpackage

//--- design/ddc_macros.svh
/* DDC constants
   Settings and readback addresses, datapath widths and limits */
`ifndef DDC_MACROS_SVH
`define DDC_MACROS_SVH

// Settings bus addresses, user register space
`define SR_FREQ_ADDR      8'd132
`define SR_SCALE_IQ_ADDR  8'd133
`define SR_DECIM_ADDR     8'd134
`define SR_MUX_ADDR       8'd135

// Readback addresses
`define RB_COMPAT_NUM     8'd0
`define RB_CIC_ORDER      8'd1
`define RB_CIC_MAX_DECIM  8'd2

// Major in the upper word, minor in the lower word
`define COMPAT_NUM        64'h0000_0001_0000_0000
`define RB_DEFAULT        64'h0BAD_C0DE_0BAD_C0DE

`define CIC_MAX_DECIM     255
`define CIC_ORDER         2

`define SAMPLE_W          16
`define PHASE_W           32
`define NCO_AMP           16384

`endif
